// File: source/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath widths
`define CPU_DATA_W   32
`define CPU_INSTR_W  24
`define CPU_ADDR_W   24
`define CPU_REG_AW   4
`define CPU_LINK_REG 14   // JSR return address lands here

// Opcodes in instr[23:19]
`define OP_ADD   5'd0
`define OP_SUB   5'd1
`define OP_AND   5'd2
`define OP_OR    5'd3
`define OP_XOR   5'd4
`define OP_CMP   5'd5
`define OP_LD    5'd6
`define OP_STO   5'd7
`define OP_MOV   5'd8
`define OP_MOVT  5'd9
`define OP_JMP   5'd10
`define OP_JSR   5'd11
`define OP_JRCC  5'd12

// JRCC conditions, 14 and 15 are unconditional
`define COND_EQ  4'd0
`define COND_NE  4'd1
`define COND_CS  4'd2
`define COND_CC  4'd3
`define COND_MI  4'd4
`define COND_PL  4'd5
`define COND_VS  4'd6
`define COND_VC  4'd7
`define COND_HI  4'd8
`define COND_LS  4'd9
`define COND_GE  4'd10
`define COND_LT  4'd11
`define COND_GT  4'd12
`define COND_LE  4'd13

`endif

// File: source/cpu_pkg.sv
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

  typedef logic [`CPU_DATA_W-1:0] word_t;
  typedef logic [`CPU_ADDR_W-1:0] addr_t;
  typedef logic [`CPU_REG_AW-1:0] reg_idx_t;

  typedef enum logic [4:0] {
    OP_ADD  = `OP_ADD,
    OP_SUB  = `OP_SUB,
    OP_AND  = `OP_AND,
    OP_OR   = `OP_OR,
    OP_XOR  = `OP_XOR,
    OP_CMP  = `OP_CMP,
    OP_LD   = `OP_LD,
    OP_STO  = `OP_STO,
    OP_MOV  = `OP_MOV,
    OP_MOVT = `OP_MOVT,
    OP_JMP  = `OP_JMP,
    OP_JSR  = `OP_JSR,
    OP_JRCC = `OP_JRCC
  } opcode_e;

  // One instruction word, three field layouts
  typedef union packed {
    struct packed {
      logic [4:0] op;
      logic       imm_sel;
      reg_idx_t   rdst;
      reg_idx_t   rsrc0;
      reg_idx_t   rsrc1;
      logic [5:0] zero;
    } reg_fmt;
    struct packed {
      logic [4:0] op;
      logic       imm_sel;
      reg_idx_t   rdst;
      reg_idx_t   rsrc0;
      logic [9:0] imm;
    } short_fmt;
    struct packed {
      logic [4:0]  op;
      logic        imm_sel;
      reg_idx_t    rdst;    // Condition code for JRCC
      logic [13:0] imm;
    } long_fmt;
  } instr_u;

  typedef struct packed {
    logic c;
    logic v;
    logic s;
    logic z;
  } flags_t;

  typedef struct packed {
    instr_u instr;
    addr_t  pc;
    logic   valid;
  } fetch_t;

  typedef struct packed {
    logic     valid;
    opcode_e  op;
    logic [3:0] cond;
    reg_idx_t rdst;
    logic     wr_lo;
    logic     wr_hi;
    word_t    src_a;
    word_t    src_b;
    addr_t    pc;
  } exec_t;

  typedef struct packed {
    logic  taken;
    addr_t target;
  } redirect_t;

endpackage

`default_nettype wire

// File: source/cpu_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_fetch (
  input  wire logic                    i_clk,
  input  wire logic                    i_rstb,
  input  wire logic [`CPU_INSTR_W-1:0] i_instr,
  input  wire cpu_pkg::redirect_t      i_redirect,
  output cpu_pkg::addr_t               o_iaddr,
  output cpu_pkg::fetch_t              o_fetch
);

  cpu_pkg::addr_t pc_q;       // Address of the word now on i_instr
  cpu_pkg::addr_t next_pc;
  logic           started_q;  // Low for the first cycle out of reset

  always_comb begin
    if (i_redirect.taken) begin
      next_pc = i_redirect.target;
    end else if (started_q) begin
      next_pc = pc_q + 1'b1;
    end else begin
      next_pc = pc_q;        // Hold address 0 until the ROM has it
    end
  end

  assign o_iaddr = next_pc;

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb) begin
      pc_q      <= '0;
      started_q <= 1'b0;
    end else begin
      pc_q      <= next_pc;
      started_q <= 1'b1;
    end
  end

  // The word behind a taken jump is dropped here
  always_comb begin
    o_fetch.instr = i_instr;
    o_fetch.pc    = pc_q;
    o_fetch.valid = started_q && !i_redirect.taken;
  end

endmodule

`default_nettype wire

// File: source/cpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_regfile (
  input  wire logic              i_clk,
  input  wire logic              i_rstb,
  input  wire cpu_pkg::reg_idx_t i_raddr_0,
  input  wire cpu_pkg::reg_idx_t i_raddr_1,
  input  wire logic              i_wr_lo,
  input  wire logic              i_wr_hi,
  input  wire cpu_pkg::reg_idx_t i_wr_idx,
  input  wire cpu_pkg::word_t    i_wr_data,
  output cpu_pkg::word_t         o_rdata_0,
  output cpu_pkg::word_t         o_rdata_1
);

  cpu_pkg::word_t regs [0:(1 << `CPU_REG_AW)-1];
  cpu_pkg::word_t wr_mask;

  // Write-through merges the halfwords being written this cycle
  function automatic cpu_pkg::word_t read_port(input cpu_pkg::reg_idx_t idx,
                                               input cpu_pkg::word_t   stored,
                                               input cpu_pkg::reg_idx_t wr_idx,
                                               input cpu_pkg::word_t   mask,
                                               input cpu_pkg::word_t   data);
    if (idx == '0) begin
      return '0;             // R0 reads zero
    end
    if (idx == wr_idx) begin
      return (stored & ~mask) | (data & mask);
    end
    return stored;
  endfunction

  assign wr_mask   = {{16{i_wr_hi}}, {16{i_wr_lo}}};
  assign o_rdata_0 = read_port(i_raddr_0, regs[i_raddr_0], i_wr_idx, wr_mask, i_wr_data);
  assign o_rdata_1 = read_port(i_raddr_1, regs[i_raddr_1], i_wr_idx, wr_mask, i_wr_data);

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb) begin
      for (int i = 0; i < (1 << `CPU_REG_AW); i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr_idx != '0) begin
      if (i_wr_lo) regs[i_wr_idx][15:0]  <= i_wr_data[15:0];
      if (i_wr_hi) regs[i_wr_idx][31:16] <= i_wr_data[31:16];
    end
  end

endmodule

`default_nettype wire

// File: source/cpu_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_decode (
  input  wire logic              i_clk,
  input  wire logic              i_rstb,
  input  wire cpu_pkg::fetch_t   i_fetch,
  input  wire logic              i_wr_lo,
  input  wire logic              i_wr_hi,
  input  wire cpu_pkg::reg_idx_t i_wr_idx,
  input  wire cpu_pkg::word_t    i_wr_data,
  output cpu_pkg::exec_t         o_exec,
  output cpu_pkg::addr_t         o_daddr,
  output cpu_pkg::word_t         o_dout,
  output logic                   o_ram_rd,
  output logic                   o_ram_wr
);

  cpu_pkg::instr_u  instr;
  cpu_pkg::opcode_e op;
  cpu_pkg::word_t   rdata_0;
  cpu_pkg::word_t   rdata_1;
  cpu_pkg::word_t   imm;
  cpu_pkg::word_t   opnd_b;
  logic             long_form;
  logic             use_imm;
  logic             wr_full;    // Both halfwords written
  cpu_pkg::exec_t   exec_d;
  cpu_pkg::exec_t   data_q;
  logic             valid_q;
  logic             wr_lo_q;
  logic             wr_hi_q;

  assign instr = i_fetch.instr;
  assign op    = cpu_pkg::opcode_e'(instr.reg_fmt.op);

  cpu_regfile u_regfile (
    .i_clk     (i_clk),
    .i_rstb    (i_rstb),
    .i_raddr_0 (instr.reg_fmt.rsrc0),
    .i_raddr_1 (instr.reg_fmt.rsrc1),
    .i_wr_lo   (i_wr_lo),
    .i_wr_hi   (i_wr_hi),
    .i_wr_idx  (i_wr_idx),
    .i_wr_data (i_wr_data),
    .o_rdata_0 (rdata_0),
    .o_rdata_1 (rdata_1)
  );

  // Immediate extraction and operand B
  always_comb begin
    long_form = (op == cpu_pkg::OP_MOV) || (op == cpu_pkg::OP_MOVT) ||
                (op == cpu_pkg::OP_JSR) || (op == cpu_pkg::OP_JRCC) ||
                ((op == cpu_pkg::OP_JMP) && instr.long_fmt.imm_sel);
    use_imm   = long_form || instr.reg_fmt.imm_sel;
    if (long_form) begin
      case (op)
        cpu_pkg::OP_JRCC: imm = {{18{instr.long_fmt.imm[13]}}, instr.long_fmt.imm};
        cpu_pkg::OP_MOVT: imm = {2'b00, instr.long_fmt.imm, 16'h0000};
        default:          imm = {18'b0, instr.long_fmt.imm};
      endcase
    end else if ((op == cpu_pkg::OP_ADD) || (op == cpu_pkg::OP_SUB) ||
                 (op == cpu_pkg::OP_CMP)) begin
      imm = {{22{instr.short_fmt.imm[9]}}, instr.short_fmt.imm};
    end else begin
      imm = {22'b0, instr.short_fmt.imm};
    end
    opnd_b = use_imm ? imm : rdata_1;
  end

  always_comb begin
    case (op)
      cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR,
      cpu_pkg::OP_XOR, cpu_pkg::OP_LD, cpu_pkg::OP_MOV, cpu_pkg::OP_JSR: wr_full = 1'b1;
      default: wr_full = 1'b0;  // CMP, STO and jumps leave the file alone
    endcase
  end

  always_comb begin
    exec_d.valid = i_fetch.valid;
    exec_d.op    = op;
    exec_d.cond  = instr.long_fmt.rdst;
    exec_d.rdst  = (op == cpu_pkg::OP_JSR) ? cpu_pkg::reg_idx_t'(`CPU_LINK_REG)
                                           : instr.reg_fmt.rdst;
    exec_d.wr_lo = i_fetch.valid && wr_full;
    exec_d.wr_hi = i_fetch.valid && (wr_full || (op == cpu_pkg::OP_MOVT));
    exec_d.src_a = rdata_0;
    exec_d.src_b = opnd_b;
    exec_d.pc    = i_fetch.pc;
  end

  // Data memory strobes straight from the decoded word
  assign o_ram_rd = i_fetch.valid && (op == cpu_pkg::OP_LD);
  assign o_ram_wr = i_fetch.valid && (op == cpu_pkg::OP_STO);
  assign o_daddr  = opnd_b[`CPU_ADDR_W-1:0];
  assign o_dout   = rdata_0;

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb) begin
      valid_q <= 1'b0;
      wr_lo_q <= 1'b0;
      wr_hi_q <= 1'b0;
    end else begin
      valid_q <= exec_d.valid;
      wr_lo_q <= exec_d.wr_lo;
      wr_hi_q <= exec_d.wr_hi;
    end
  end

  always_ff @(posedge i_clk) begin
    data_q <= exec_d;
  end

  always_comb begin
    o_exec       = data_q;
    o_exec.valid = valid_q;
    o_exec.wr_lo = wr_lo_q;
    o_exec.wr_hi = wr_hi_q;
  end

endmodule

`default_nettype wire

// File: source/cpu_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_execute (
  input  wire logic           i_clk,
  input  wire logic           i_rstb,
  input  wire cpu_pkg::exec_t i_exec,
  input  wire cpu_pkg::word_t i_din,
  output cpu_pkg::redirect_t  o_redirect,
  output logic                o_wr_lo,
  output logic                o_wr_hi,
  output cpu_pkg::reg_idx_t   o_wr_idx,
  output cpu_pkg::word_t      o_wr_data
);

  cpu_pkg::flags_t      flags_q;
  cpu_pkg::flags_t      flags_d;
  cpu_pkg::word_t       b_in;
  cpu_pkg::word_t       alu_res;
  cpu_pkg::addr_t       link_pc;
  logic [`CPU_DATA_W:0] sum;         // Carry in the top bit
  logic                 is_sub;
  logic                 is_arith;
  logic                 is_logic;
  logic                 cond_ok;

  // ALU
  always_comb begin
    is_sub   = (i_exec.op == cpu_pkg::OP_SUB) || (i_exec.op == cpu_pkg::OP_CMP);
    is_arith = is_sub || (i_exec.op == cpu_pkg::OP_ADD);
    is_logic = (i_exec.op == cpu_pkg::OP_AND) || (i_exec.op == cpu_pkg::OP_OR) ||
               (i_exec.op == cpu_pkg::OP_XOR);
    b_in     = is_sub ? ~i_exec.src_b : i_exec.src_b;
    sum      = {1'b0, i_exec.src_a} + {1'b0, b_in} + {{`CPU_DATA_W{1'b0}}, is_sub};
    case (i_exec.op)
      cpu_pkg::OP_AND: alu_res = i_exec.src_a & i_exec.src_b;
      cpu_pkg::OP_OR:  alu_res = i_exec.src_a | i_exec.src_b;
      cpu_pkg::OP_XOR: alu_res = i_exec.src_a ^ i_exec.src_b;
      default:         alu_res = sum[`CPU_DATA_W-1:0];
    endcase
  end

  always_comb begin
    flags_d = flags_q;                // Loads, moves and jumps keep the flags
    if (i_exec.valid && (is_arith || is_logic)) begin
      flags_d.c = is_arith && sum[`CPU_DATA_W];
      flags_d.v = is_arith && (i_exec.src_a[31] == b_in[31]) &&
                  (alu_res[31] != i_exec.src_a[31]);
      flags_d.s = alu_res[31];
      flags_d.z = (alu_res == '0);
    end
  end

  always_ff @(posedge i_clk or negedge i_rstb) begin
    if (!i_rstb) begin
      flags_q <= '0;
    end else begin
      flags_q <= flags_d;
    end
  end

  always_comb begin
    case (i_exec.cond)
      `COND_EQ: cond_ok = flags_q.z;
      `COND_NE: cond_ok = !flags_q.z;
      `COND_CS: cond_ok = flags_q.c;
      `COND_CC: cond_ok = !flags_q.c;
      `COND_MI: cond_ok = flags_q.s;
      `COND_PL: cond_ok = !flags_q.s;
      `COND_VS: cond_ok = flags_q.v;
      `COND_VC: cond_ok = !flags_q.v;
      `COND_HI: cond_ok = flags_q.c && !flags_q.z;
      `COND_LS: cond_ok = !flags_q.c || flags_q.z;
      `COND_GE: cond_ok = (flags_q.s == flags_q.v);
      `COND_LT: cond_ok = (flags_q.s != flags_q.v);
      `COND_GT: cond_ok = !flags_q.z && (flags_q.s == flags_q.v);
      `COND_LE: cond_ok = flags_q.z || (flags_q.s != flags_q.v);
      default:  cond_ok = 1'b1;       // Always
    endcase
  end

  // Jump resolution, PC relative only for JRCC
  always_comb begin
    o_redirect.taken  = i_exec.valid &&
                        ((i_exec.op == cpu_pkg::OP_JMP) || (i_exec.op == cpu_pkg::OP_JSR) ||
                         ((i_exec.op == cpu_pkg::OP_JRCC) && cond_ok));
    o_redirect.target = (i_exec.op == cpu_pkg::OP_JRCC) ?
                        i_exec.pc + i_exec.src_b[`CPU_ADDR_W-1:0] :
                        i_exec.src_b[`CPU_ADDR_W-1:0];
  end

  assign link_pc = i_exec.pc + 1'b1;

  // Write-back
  always_comb begin
    case (i_exec.op)
      cpu_pkg::OP_LD:   o_wr_data = i_din;
      cpu_pkg::OP_JSR:  o_wr_data = {{(`CPU_DATA_W-`CPU_ADDR_W){1'b0}}, link_pc};
      cpu_pkg::OP_MOV,
      cpu_pkg::OP_MOVT: o_wr_data = i_exec.src_b;
      default:          o_wr_data = alu_res;
    endcase
  end

  assign o_wr_lo  = i_exec.wr_lo;   // Already qualified by valid
  assign o_wr_hi  = i_exec.wr_hi;
  assign o_wr_idx = i_exec.rdst;

endmodule

`default_nettype wire

// File: source/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_top (
  input  wire logic                    i_clk,
  input  wire logic                    i_rstb,
  input  wire logic [`CPU_INSTR_W-1:0] i_instr,
  input  wire cpu_pkg::word_t          i_din,
  output cpu_pkg::addr_t               o_iaddr,
  output cpu_pkg::addr_t               o_daddr,
  output cpu_pkg::word_t               o_dout,
  output logic                         o_ram_rd,
  output logic                         o_ram_wr
);

  cpu_pkg::fetch_t    fetch;
  cpu_pkg::exec_t     exec;
  cpu_pkg::redirect_t redirect;
  logic               wr_lo;
  logic               wr_hi;
  cpu_pkg::reg_idx_t  wr_idx;
  cpu_pkg::word_t     wr_data;

  cpu_fetch u_fetch (
    .i_clk      (i_clk),
    .i_rstb     (i_rstb),
    .i_instr    (i_instr),
    .i_redirect (redirect),
    .o_iaddr    (o_iaddr),
    .o_fetch    (fetch)
  );

  cpu_decode u_decode (
    .i_clk     (i_clk),
    .i_rstb    (i_rstb),
    .i_fetch   (fetch),
    .i_wr_lo   (wr_lo),
    .i_wr_hi   (wr_hi),
    .i_wr_idx  (wr_idx),
    .i_wr_data (wr_data),
    .o_exec    (exec),
    .o_daddr   (o_daddr),
    .o_dout    (o_dout),
    .o_ram_rd  (o_ram_rd),
    .o_ram_wr  (o_ram_wr)
  );

  cpu_execute u_execute (
    .i_clk      (i_clk),
    .i_rstb     (i_rstb),
    .i_exec     (exec),
    .i_din      (i_din),
    .o_redirect (redirect),
    .o_wr_lo    (wr_lo),
    .o_wr_hi    (wr_hi),
    .o_wr_idx   (wr_idx),
    .o_wr_data  (wr_data)
  );

endmodule

`default_nettype wire

// File: verification/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module tb_cpu;

  typedef struct packed {
    cpu_pkg::addr_t addr;
    cpu_pkg::word_t data;
  } store_t;

  logic                    i_clk;
  logic                    i_rstb;
  logic [`CPU_INSTR_W-1:0] i_instr;
  cpu_pkg::word_t          i_din;
  cpu_pkg::addr_t          o_iaddr;
  cpu_pkg::addr_t          o_daddr;
  cpu_pkg::word_t          o_dout;
  logic                    o_ram_rd;
  logic                    o_ram_wr;

  logic [`CPU_INSTR_W-1:0] rom [0:1023];
  cpu_pkg::word_t          ram [0:1023];
  cpu_pkg::addr_t          exp_loads [$];
  store_t                  exp_stores [$];
  store_t                  exp_st;
  logic [31:0]             lfsr_q;
  int                      gen_pc;
  int                      store_ptr;
  cpu_pkg::addr_t          halt_pc;
  int                      errors;
  int                      checks;
  int                      loads_seen;
  int                      stores_seen;
  int                      after_release;
  int                      cycles;
  int                      limit;

  cpu_top u_cpu_top (
    .i_clk    (i_clk),
    .i_rstb   (i_rstb),
    .i_instr  (i_instr),
    .i_din    (i_din),
    .o_iaddr  (o_iaddr),
    .o_daddr  (o_daddr),
    .o_dout   (o_dout),
    .o_ram_rd (o_ram_rd),
    .o_ram_wr (o_ram_wr)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // Synchronous ROM and RAM, one cycle from address to data
  always @(posedge i_clk) begin
    i_instr <= rom[o_iaddr[9:0]];
    if (o_ram_wr) ram[o_daddr[9:0]] <= o_dout;
    if (o_ram_rd) i_din <= ram[o_daddr[9:0]];
  end

  // Galois LFSR, one step per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  function automatic cpu_pkg::reg_idx_t pick_reg();
    return cpu_pkg::reg_idx_t'(rand_bits(3) + 1);   // R1 to R8
  endfunction

  function automatic logic [31:0] next_store();
    store_ptr++;
    return store_ptr - 1;
  endfunction

  function automatic cpu_pkg::instr_u reg_form(input logic [4:0] op, input cpu_pkg::reg_idx_t rd,
                                               input cpu_pkg::reg_idx_t ra,
                                               input cpu_pkg::reg_idx_t rb);
    cpu_pkg::instr_u w;
    w               = '0;
    w.reg_fmt.op    = op;
    w.reg_fmt.rdst  = rd;
    w.reg_fmt.rsrc0 = ra;
    w.reg_fmt.rsrc1 = rb;
    return w;
  endfunction

  function automatic cpu_pkg::instr_u short_form(input logic [4:0] op,
                                                 input cpu_pkg::reg_idx_t rd,
                                                 input cpu_pkg::reg_idx_t ra,
                                                 input logic [31:0] imm);
    cpu_pkg::instr_u w;
    w                   = '0;
    w.short_fmt.op      = op;
    w.short_fmt.imm_sel = 1'b1;
    w.short_fmt.rdst    = rd;
    w.short_fmt.rsrc0   = ra;
    w.short_fmt.imm     = imm[9:0];
    return w;
  endfunction

  function automatic cpu_pkg::instr_u long_form(input logic [4:0] op, input logic [3:0] rd,
                                                input logic [31:0] imm);
    cpu_pkg::instr_u w;
    w                  = '0;
    w.long_fmt.op      = op;
    w.long_fmt.imm_sel = 1'b1;
    w.long_fmt.rdst    = rd;
    w.long_fmt.imm     = imm[13:0];
    return w;
  endfunction

  task automatic emit(input cpu_pkg::instr_u w);
    rom[gen_pc] = w;
    gen_pc++;
  endtask

  task automatic build_program();
    logic [4:0]        alu_ops [0:4];
    cpu_pkg::reg_idx_t ra;
    cpu_pkg::reg_idx_t rb;
    alu_ops = '{`OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_XOR};
    for (int i = 0; i < 1024; i++) begin
      rom[i] = long_form(`OP_JMP, 4'd0, i);   // Unused words trap on themselves
      ram[i] = rand_bits(32);
    end
    gen_pc    = 0;
    store_ptr = 'h100;
    for (int r = 1; r <= 8; r++) begin
      emit(long_form(`OP_MOV, 4'(r), rand_bits(14)));
      emit(long_form(`OP_MOVT, 4'(r), rand_bits(14)));
    end
    for (int r = 5; r <= 8; r++) begin
      emit(reg_form(`OP_SUB, 4'(r), 4'd0, 4'(r)));   // Negative values from R0 minus Rn
    end
    for (int r = 1; r <= 8; r++) begin
      emit(short_form(`OP_STO, 4'd0, 4'(r), next_store()));
    end
    emit(short_form(`OP_LD, 4'd9, 4'd0, rand_bits(6)));
    emit(short_form(`OP_STO, 4'd0, 4'd9, next_store()));
    emit(long_form(`OP_MOV, 4'd11, rand_bits(6)));
    emit(reg_form(`OP_LD, 4'd10, 4'd0, 4'd11));
    emit(short_form(`OP_STO, 4'd0, 4'd10, next_store()));
    emit(long_form(`OP_MOVT, 4'd10, rand_bits(14)));   // Upper half only
    emit(short_form(`OP_STO, 4'd0, 4'd10, next_store()));
    // Dependent chains through R12 and R13
    for (int k = 0; k < 5; k++) begin
      emit(reg_form(alu_ops[k], 4'd12, pick_reg(), pick_reg()));
      emit(reg_form(alu_ops[k], 4'd13, 4'd12, pick_reg()));
      emit(short_form(alu_ops[k], 4'd12, 4'd13, rand_bits(10)));
      emit(short_form(`OP_STO, 4'd0, 4'd12, next_store()));
      emit(short_form(`OP_STO, 4'd0, 4'd13, next_store()));
    end
    for (int c = 0; c < 16; c++) begin
      ra = pick_reg();
      rb = rand_bits(1) ? ra : pick_reg();
      case (c % 3)
        0:       emit(reg_form(`OP_CMP, 4'd0, ra, rb));
        1:       emit(reg_form(`OP_SUB, 4'd15, ra, rb));
        default: emit(short_form(`OP_CMP, 4'd0, ra, rand_bits(10)));
      endcase
      emit(long_form(`OP_JRCC, 4'(c), 2));   // Taken skips the marker store
      emit(short_form(`OP_STO, 4'd0, ra, next_store()));
    end
    emit(long_form(`OP_JSR, 4'd0, 'h200));
    emit(short_form(`OP_STO, 4'd0, 4'd15, next_store()));
    halt_pc = cpu_pkg::addr_t'(gen_pc);
    emit(long_form(`OP_JMP, 4'd0, gen_pc));
    gen_pc = 'h200;                          // Subroutine
    emit(short_form(`OP_STO, 4'd0, 4'd14, next_store()));
    emit(short_form(`OP_ADD, 4'd15, 4'd14, rand_bits(10)));
    emit(reg_form(`OP_JMP, 4'd0, 4'd0, 4'd14));
  endtask

  function automatic logic cond_true(input logic [3:0] cc, input logic c, input logic v,
                                     input logic s, input logic z);
    case (cc)
      `COND_EQ: return z;
      `COND_NE: return ~z;
      `COND_CS: return c;
      `COND_CC: return ~c;
      `COND_MI: return s;
      `COND_PL: return ~s;
      `COND_VS: return v;
      `COND_VC: return ~v;
      `COND_HI: return c & ~z;
      `COND_LS: return ~(c & ~z);
      `COND_GE: return ~(s ^ v);
      `COND_LT: return s ^ v;
      `COND_GT: return ~z & ~(s ^ v);
      `COND_LE: return z | (s ^ v);
      default:  return 1'b1;
    endcase
  endfunction

  // Instruction-level interpreter, returns the number of executed words
  function automatic int ref_run();
    cpu_pkg::word_t  regs [0:15];
    cpu_pkg::word_t  mem [0:1023];
    cpu_pkg::instr_u w;
    cpu_pkg::word_t  a;
    cpu_pkg::word_t  b;
    cpu_pkg::word_t  res;
    cpu_pkg::addr_t  pc;
    cpu_pkg::addr_t  next_pc;
    logic [32:0]     wide;
    logic            c;
    logic            v;
    logic            s;
    logic            z;
    logic            wr;
    logic            alu;
    logic            halted;
    int              count;
    store_t          st;
    for (int i = 0; i < 16; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < 1024; i++) begin
      mem[i] = ram[i];
    end
    {c, v, s, z} = 4'b0;
    pc     = '0;
    count  = 0;
    halted = 1'b0;
    while (!halted && (count < 4096)) begin
      w       = rom[pc[9:0]];
      count++;
      next_pc = pc + 24'd1;
      wr      = 1'b0;
      alu     = 1'b0;
      a       = regs[w.reg_fmt.rsrc0];
      if (w.reg_fmt.op inside {`OP_ADD, `OP_SUB, `OP_CMP}) begin
        b = {{22{w.short_fmt.imm[9]}}, w.short_fmt.imm};
      end else begin
        b = {22'b0, w.short_fmt.imm};
      end
      if (!w.reg_fmt.imm_sel) b = regs[w.reg_fmt.rsrc1];
      case (w.reg_fmt.op)
        `OP_ADD: begin
          wide = {1'b0, a} + {1'b0, b};
          res  = wide[31:0];
          c    = wide[32];
          v    = (a[31] == b[31]) && (res[31] != a[31]);
          {wr, alu} = 2'b11;
        end
        `OP_SUB, `OP_CMP: begin
          res = a - b;
          c   = (a >= b);                    // No borrow
          v   = (a[31] != b[31]) && (res[31] != a[31]);
          wr  = (w.reg_fmt.op == `OP_SUB);
          alu = 1'b1;
        end
        `OP_AND, `OP_OR, `OP_XOR: begin
          if (w.reg_fmt.op == `OP_AND) begin
            res = a & b;
          end else if (w.reg_fmt.op == `OP_OR) begin
            res = a | b;
          end else begin
            res = a ^ b;
          end
          {c, v}    = 2'b00;
          {wr, alu} = 2'b11;
        end
        `OP_LD: begin
          exp_loads.push_back(b[23:0]);
          res = mem[b[9:0]];
          wr  = 1'b1;
        end
        `OP_STO: begin
          st.addr = b[23:0];
          st.data = a;
          exp_stores.push_back(st);
          mem[b[9:0]] = a;
        end
        `OP_MOV: begin
          res = {18'b0, w.long_fmt.imm};
          wr  = 1'b1;
        end
        `OP_MOVT: begin
          if (w.long_fmt.rdst != 0) begin
            regs[w.long_fmt.rdst][31:16] = {2'b00, w.long_fmt.imm};
          end
        end
        `OP_JMP: begin
          next_pc = w.long_fmt.imm_sel ? {10'b0, w.long_fmt.imm} : regs[w.reg_fmt.rsrc1][23:0];
          halted  = (next_pc == pc);
        end
        `OP_JSR: begin
          regs[`CPU_LINK_REG] = {8'b0, pc + 24'd1};
          next_pc = {10'b0, w.long_fmt.imm};
        end
        `OP_JRCC: if (cond_true(w.long_fmt.rdst, c, v, s, z)) begin
          next_pc = pc + {{10{w.long_fmt.imm[13]}}, w.long_fmt.imm};
        end
        default: ;
      endcase
      if (alu) {s, z} = {res[31], res == 0};
      if (wr && (w.reg_fmt.rdst != 0)) regs[w.reg_fmt.rdst] = res;
      pc = next_pc;
    end
    return count;
  endfunction

  task automatic check_addr(input string name, input cpu_pkg::addr_t got,
                            input cpu_pkg::addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input cpu_pkg::word_t got,
                            input cpu_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // Compare the memory ports against the model queues, away from the clock edge
  always @(negedge i_clk) begin
    if (!i_rstb || (after_release == 0)) begin
      check_addr("o_iaddr", o_iaddr, '0);
      check_bit("o_ram_rd", o_ram_rd, 1'b0);
      check_bit("o_ram_wr", o_ram_wr, 1'b0);
    end
    if (i_rstb) after_release++;
    if (o_ram_rd) begin
      loads_seen++;
      if (exp_loads.size() == 0) begin
        errors++;
        $display("Unexpected load from %h at %0t, the model has no more loads", o_daddr, $time);
      end else begin
        check_addr("o_daddr", o_daddr, exp_loads.pop_front());
      end
    end
    if (o_ram_wr) begin
      stores_seen++;
      if (exp_stores.size() == 0) begin
        errors++;
        $display("Extra store of %h to %h at %0t", o_dout, o_daddr, $time);
      end else begin
        exp_st = exp_stores.pop_front();
        check_addr("o_daddr", o_daddr, exp_st.addr);
        check_word("o_dout", o_dout, exp_st.data);
      end
    end
  end

  initial begin
    i_rstb        = 1'b0;
    i_instr       = '0;
    i_din         = '0;
    lfsr_q        = 32'h9971;
    errors        = 0;
    checks        = 0;
    loads_seen    = 0;
    stores_seen   = 0;
    after_release = 0;
    cycles        = 0;
    build_program();
    limit = 3 * ref_run() + 50;
    repeat (3) @(posedge i_clk);
    i_rstb <= 1'b1;
    while ((o_iaddr != halt_pc) && (cycles < limit)) begin
      @(negedge i_clk);
      cycles++;
    end
    if (cycles >= limit) begin
      errors++;
      $display("Timeout after %0d cycles, the program never reached its final jump", cycles);
    end else begin
      repeat (3) @(negedge i_clk);   // Let the last words leave the pipeline
      if (exp_stores.size() != 0) begin
        errors++;
        $display("%0d expected stores never happened", exp_stores.size());
      end
      if (exp_loads.size() != 0) begin
        errors++;
        $display("%0d expected loads never happened", exp_loads.size());
      end
    end
    $display("Checks %0d, errors %0d, loads %0d, stores %0d", checks, errors, loads_seen,
             stores_seen);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+source
source/cpu_pkg.sv
source/cpu_fetch.sv
source/cpu_regfile.sv
source/cpu_decode.sv
source/cpu_execute.sv
source/cpu_top.sv
verification/tb_cpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the Verilator model of tb_cpu, run it and scan the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_cpu -o tb_cpu \
  && ./obj_dir/tb_cpu > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -q "Everything OK" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
